// File: verilog.f
+incdir+source
source/issue_inst_pkg.sv
source/issue_ctrl_pkg.sv
source/credit_counter.sv
source/wait_buffer.sv
source/rr_dispatch_arbiter.sv
source/issue_ctrl.sv
source/issue_top.sv
tb/issue_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = issue_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/issue_tb.sv
// ################################################
// Testbench for the issue stage
// Stimulus table, slot model and per-cycle checks
// ################################################

`include "issue_settings.svh"

module issue_tb
    import issue_inst_pkg::*;
    import issue_ctrl_pkg::*;
();

    localparam int N_TESTS = 5;
    localparam int N_INSTS = 18;
    localparam int N_WAKES = 6;
    localparam int PERIOD  = 40;

    // One row per test
    typedef struct packed {
        logic [3:0] n_inst;
        logic [4:0] first;
        logic [3:0] stall;
        // One bit per tag value
        logic [7:0] expect_tags;
    } test_row_t;

    typedef struct packed {
        opcode_e    op;
        tag_t       tag;
        logic [1:0] rdy;
        tag_t       src1;
        tag_t       src0;
    } inst_row_t;

    typedef struct packed {
        logic [2:0] test;
        logic [4:0] cycle;
        tag_t       tag;
    } wake_row_t;

    test_row_t tests [N_TESTS];
    inst_row_t insts [N_INSTS];
    wake_row_t wakes [N_WAKES];

    logic       clk;
    logic       reset;
    logic       fetch_req;
    logic       fetch_grant;
    logic       dec_valid;
    dec_inst_t  dec_inst;
    logic       opc_ready;
    logic       disp_valid;
    disp_inst_t disp_inst;
    logic       eu_valid;
    tag_t       eu_tag;

    // Slot model of the wait buffer and the credit count
    logic [`ISSUE_ENTRIES-1:0]                     m_valid;
    dec_inst_t [`ISSUE_ENTRIES-1:0]                m_inst;
    int                                            m_credits;
    // Positions that each position waits for before it fires again
    logic [`ISSUE_ENTRIES-1:0][`ISSUE_ENTRIES-1:0] pending;

    int          errors;
    int          checks;
    logic [31:0] rng;

    issue_top dut0 (
        .clk_i         (clk),
        .reset_i       (reset),
        .fetch_req_i   (fetch_req),
        .fetch_grant_o (fetch_grant),
        .dec_valid_i   (dec_valid),
        .dec_inst_i    (dec_inst),
        .opc_ready_i   (opc_ready),
        .disp_valid_o  (disp_valid),
        .disp_inst_o   (disp_inst),
        .eu_valid_i    (eu_valid),
        .eu_tag_i      (eu_tag)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ################################################
    // Helpers
    // ################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAIL %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // Table fields plus random pc, mask and registers
    task automatic make_inst(input inst_row_t r, output dec_inst_t d);
        rng = xorshift(rng);
        d.pc = {rng[31:2], 2'b00};
        rng = xorshift(rng);
        d.act_mask = rng[7:0];
        d.dst_reg = rng[13:8];
        d.operands[0] = rng[19:14];
        d.operands[1] = rng[25:20];
        d.opcode = r.op;
        d.tag = r.tag;
        d.operands_ready = r.rdy;
        d.operand_tags[0] = r.src0;
        d.operand_tags[1] = r.src1;
    endtask

    // Valid entries whose operands are all ready
    function automatic logic [`ISSUE_ENTRIES-1:0] model_ready();
        logic [`ISSUE_ENTRIES-1:0] r;
        for (int i = 0; i < `ISSUE_ENTRIES; i++) begin
            r[i] = m_valid[i] && (&m_inst[i].operands_ready);
        end
        return r;
    endfunction

    // ################################################
    // Stimulus table
    // ################################################

    task automatic fill_tables();
        // n_inst, first row in insts, stall cycles, expected tag set
        tests = '{'{4'd1, 5'd0, 4'd0, 8'h02}, '{4'd6, 5'd1, 4'd12, 8'h3f},
                  '{4'd2, 5'd7, 4'd0, 8'h0c}, '{4'd5, 5'd9, 4'd4, 8'hd3},
                  '{4'd4, 5'd14, 4'd8, 8'hac}};
        // opcode, tag, ready bits, tag of operand 1, tag of operand 0
        insts = '{'{OP_ALU, 3'd1, 2'b11, 3'd0, 3'd0},
                  '{OP_ALU, 3'd0, 2'b11, 3'd0, 3'd0}, '{OP_MUL, 3'd1, 2'b11, 3'd0, 3'd0},
                  '{OP_LOAD, 3'd2, 2'b11, 3'd0, 3'd0}, '{OP_STORE, 3'd3, 2'b11, 3'd0, 3'd0},
                  '{OP_BRANCH, 3'd4, 2'b11, 3'd0, 3'd0}, '{OP_ALU, 3'd5, 2'b11, 3'd0, 3'd0},
                  '{OP_MUL, 3'd2, 2'b10, 3'd0, 3'd5}, '{OP_LOAD, 3'd3, 2'b00, 3'd7, 3'd6},
                  '{OP_ALU, 3'd4, 2'b11, 3'd0, 3'd0}, '{OP_MUL, 3'd6, 2'b01, 3'd2, 3'd0},
                  '{OP_BRANCH, 3'd7, 2'b11, 3'd0, 3'd0}, '{OP_STORE, 3'd0, 2'b00, 3'd3, 3'd2},
                  '{OP_LOAD, 3'd1, 2'b11, 3'd0, 3'd0},
                  '{OP_LOAD, 3'd7, 2'b11, 3'd0, 3'd0}, '{OP_STORE, 3'd3, 2'b11, 3'd0, 3'd0},
                  '{OP_BRANCH, 3'd5, 2'b11, 3'd0, 3'd0}, '{OP_MUL, 3'd2, 2'b11, 3'd0, 3'd0}};
        // Test, cycle within the test, result tag
        wakes = '{'{3'd2, 5'd3, 3'd4}, '{3'd2, 5'd6, 3'd5}, '{3'd2, 5'd8, 3'd6},
                  '{3'd2, 5'd11, 3'd7}, '{3'd3, 5'd6, 3'd2}, '{3'd3, 5'd7, 3'd3}};
    endtask

    // ################################################
    // Test sequences
    // ################################################

    // Request held through reset and the init cycle
    task automatic check_reset();
        for (int i = 1; i <= 5; i++) begin
            @(posedge clk);
            #2;
            if (i == 5) begin
                reset = 1'b0;
            end
            #1;
            check(fetch_grant === 1'b0 && disp_valid === 1'b0,
                  $sformatf("grant %b, valid %b in reset or init", fetch_grant, disp_valid));
        end
        m_valid = '0;
        m_credits = `ISSUE_ENTRIES;
        $display("test 0: reset and init, %0d errors", errors);
    endtask

    task automatic run_test(input int t);
        test_row_t                 row;
        int                        cyc, granted, sent, last_wake, pos, ins_pos, errs_before;
        logic                      send, fire, exp_grant, exp_valid, wake;
        logic [`ISSUE_ENTRIES-1:0] rdy_now;
        logic [7:0]                seen;
        tag_t                      wake_tag;
        dec_inst_t                 d;
        row = tests[t];
        cyc = 0;
        granted = 0;
        sent = 0;
        send = 1'b0;
        seen = '0;
        pending = '0;
        errs_before = errors;
        last_wake = -1;
        for (int w = 0; w < N_WAKES; w++) begin
            if (wakes[w].test == t && int'(wakes[w].cycle) > last_wake) begin
                last_wake = int'(wakes[w].cycle);
            end
        end
        while (granted < row.n_inst || send || m_valid != '0 || cyc <= last_wake) begin
            @(posedge clk);
            #2;
            wake = 1'b0;
            wake_tag = '0;
            for (int w = 0; w < N_WAKES; w++) begin
                if (wakes[w].test == t && wakes[w].cycle == cyc) begin
                    wake = 1'b1;
                    wake_tag = wakes[w].tag;
                end
            end
            // Decoder answers the grant of the cycle before
            d = '0;
            if (send) begin
                make_inst(insts[row.first + sent], d);
            end
            fetch_req = (granted < row.n_inst);
            dec_valid = send;
            dec_inst = d;
            opc_ready = (cyc >= row.stall);
            eu_valid = wake;
            eu_tag = wake_tag;
            #1;
            rdy_now = model_ready();
            exp_grant = fetch_req && (m_credits > 0);
            exp_valid = |rdy_now;
            check(fetch_grant === exp_grant,
                  $sformatf("fetch grant %b, expected %b", fetch_grant, exp_grant));
            check(disp_valid === exp_valid,
                  $sformatf("dispatch valid %b, expected %b", disp_valid, exp_valid));
            fire = exp_valid && opc_ready;
            pos = -1;
            if (exp_valid) begin
                for (int i = 0; i < `ISSUE_ENTRIES; i++) begin
                    if (m_valid[i] && m_inst[i].tag == disp_inst.tag) begin
                        pos = i;
                    end
                end
                check(pos >= 0 && rdy_now[pos],
                      $sformatf("dispatched tag %0d is not a ready entry", disp_inst.tag));
                if (pos >= 0) begin
                    check(disp_inst.opcode == m_inst[pos].opcode
                              && disp_inst.pc == m_inst[pos].pc
                              && disp_inst.act_mask == m_inst[pos].act_mask
                              && disp_inst.dst_reg == m_inst[pos].dst_reg
                              && disp_inst.operands == m_inst[pos].operands,
                          $sformatf("fields of tag %0d differ, pc %h", disp_inst.tag,
                                    disp_inst.pc));
                end
            end
            // Every tag leaves once per test
            if (fire) begin
                check(!seen[disp_inst.tag],
                      $sformatf("tag %0d dispatched twice", disp_inst.tag));
                seen[disp_inst.tag] = 1'b1;
            end
            // Fairness among the positions that were ready
            if (fire && pos >= 0) begin
                for (int q = 0; q < `ISSUE_ENTRIES; q++) begin
                    pending[q][pos] = 1'b0;
                end
                check((pending[pos] & rdy_now) == '0,
                      $sformatf("entry %0d served again while %b wait", pos, pending[pos]));
                pending[pos] = rdy_now;
                pending[pos][pos] = 1'b0;
            end
            // Model state after the coming edge
            ins_pos = -1;
            for (int i = `ISSUE_ENTRIES - 1; i >= 0; i--) begin
                if (!m_valid[i]) begin
                    ins_pos = i;
                end
            end
            if (wake) begin
                for (int i = 0; i < `ISSUE_ENTRIES; i++) begin
                    for (int op = 0; op < `ISSUE_OPERANDS; op++) begin
                        if (m_valid[i] && m_inst[i].operand_tags[op] == wake_tag) begin
                            m_inst[i].operands_ready[op] = 1'b1;
                        end
                    end
                end
            end
            if (fire && pos >= 0) begin
                m_valid[pos] = 1'b0;
                m_credits++;
            end
            if (exp_grant) begin
                m_credits--;
            end
            if (send) begin
                check(ins_pos >= 0, "an instruction arrived while the buffer was full");
                if (ins_pos >= 0) begin
                    m_valid[ins_pos] = 1'b1;
                    m_inst[ins_pos] = d;
                end
                sent++;
            end
            if (fetch_grant) begin
                granted++;
            end
            send = fetch_grant;
            cyc++;
        end
        check(seen == row.expect_tags,
              $sformatf("dispatched tag set %b, expected %b", seen, row.expect_tags));
        $display("test %0d: %0d instructions in %0d cycles, %0d errors",
                 t + 1, sent, cyc, errors - errs_before);
    endtask

    // ################################################
    // Main sequence and watchdog
    // ################################################

    initial begin
        errors = 0;
        checks = 0;
        rng = 32'h94a;
        clk = 1'b0;
        reset = 1'b1;
        fetch_req = 1'b1;
        dec_valid = 1'b0;
        dec_inst = '0;
        opc_ready = 1'b1;
        eu_valid = 1'b0;
        eu_tag = '0;
        fill_tables();
        check_reset();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", N_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Budget of instructions plus stall plus 20 cycles per row
    initial begin
        int budget;
        #1;
        budget = 6;
        for (int t = 0; t < N_TESTS; t++) begin
            budget += tests[t].n_inst + tests[t].stall + 20;
        end
        #(budget * PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", budget);
        $display("Test failed");
        $finish;
    end

endmodule

// File: source/issue_top.sv
// ################################################
// Issue stage top level
// Control, credits, wait buffer and arbiter
// ################################################

`include "issue_settings.svh"

module issue_top
    import issue_inst_pkg::*;
    import issue_ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    // Fetcher
    input  logic       fetch_req_i,
    output logic       fetch_grant_o,
    // Decoder
    input  logic       dec_valid_i,
    input  dec_inst_t  dec_inst_i,
    // Operand collector
    input  logic       opc_ready_i,
    output logic       disp_valid_o,
    output disp_inst_t disp_inst_o,
    // Execution units
    input  logic       eu_valid_i,
    input  tag_t       eu_tag_i
);

    logic                           credit_left;
    logic                           dispatch_fire;
    logic [`ISSUE_ENTRIES-1:0]      arb_grant;
    wb_status_t                     wb_status;
    wb_entry_t [`ISSUE_ENTRIES-1:0] wb_entries;

    issue_ctrl u_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .fetch_req_i     (fetch_req_i),
        .credit_left_i   (credit_left),
        .opc_ready_i     (opc_ready_i),
        .status_i        (wb_status),
        .state_o         (),
        .fetch_grant_o   (fetch_grant_o),
        .disp_valid_o    (disp_valid_o),
        .dispatch_fire_o (dispatch_fire)
    );

    // Taken per grant, returned per dispatch
    credit_counter u_credits (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .take_i        (fetch_grant_o),
        .give_i        (dispatch_fire),
        .credit_left_o (credit_left)
    );

    wait_buffer u_buffer (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .dec_valid_i     (dec_valid_i),
        .dec_inst_i      (dec_inst_i),
        .eu_valid_i      (eu_valid_i),
        .eu_tag_i        (eu_tag_i),
        .grant_i         (arb_grant),
        .dispatch_fire_i (dispatch_fire),
        .entries_o       (wb_entries),
        .status_o        (wb_status)
    );

    rr_dispatch_arbiter u_arbiter (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .status_i        (wb_status),
        .entries_i       (wb_entries),
        .dispatch_fire_i (dispatch_fire),
        .grant_o         (arb_grant),
        .disp_inst_o     (disp_inst_o)
    );

endmodule

// File: source/issue_ctrl.sv
// ################################################
// Issue control FSM
// Fetch grant and dispatch fire
// ################################################

module issue_ctrl
    import issue_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    // Fetcher request level
    input  logic         fetch_req_i,
    // Credit counter has a free slot
    input  logic         credit_left_i,
    // Operand collector can take an instruction
    input  logic         opc_ready_i,
    input  wb_status_t   status_i,
    output issue_state_e state_o,
    output logic         fetch_grant_o,
    output logic         disp_valid_o,
    output logic         dispatch_fire_o
);

    issue_state_e state_q, state_d;

    // ################################################
    // State machine
    // ################################################

    // Init lasts one cycle after reset, run is permanent
    always_comb begin
        state_d = state_q;
        case (state_q)
            ISSUE_INIT: state_d = ISSUE_RUN;
            ISSUE_RUN:  state_d = ISSUE_RUN;
            default:    state_d = ISSUE_INIT;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ISSUE_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // ################################################
    // Handshakes
    // ################################################

    // Grant only with a credit in hand
    assign fetch_grant_o = (state_q == ISSUE_RUN) && fetch_req_i && credit_left_i;

    // Any entry with all operands ready
    assign disp_valid_o = (state_q == ISSUE_RUN) && (|status_i.ready);

    // Entry leaves and credit returns on this
    assign dispatch_fire_o = disp_valid_o && opc_ready_i;

endmodule

// File: source/rr_dispatch_arbiter.sv
// ################################################
// Round-robin selection of a ready entry
// ################################################

`include "issue_settings.svh"

module rr_dispatch_arbiter
    import issue_inst_pkg::*;
    import issue_ctrl_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  wb_status_t                     status_i,
    input  wb_entry_t [`ISSUE_ENTRIES-1:0] entries_i,
    input  logic                           dispatch_fire_i,
    // One-hot, zero when nothing is ready
    output logic [`ISSUE_ENTRIES-1:0]      grant_o,
    output disp_inst_t                     disp_inst_o
);

    localparam int IDX_W = `ISSUE_IDX_W;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_found;

    // First ready entry at or after the pointer, wrapping around
    always_comb begin
        logic [IDX_W-1:0] idx;
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int k = 0; k < `ISSUE_ENTRIES; k++) begin
            idx = ptr_q + IDX_W'(k);
            if (!sel_found && status_i.ready[idx]) begin
                sel_found = 1'b1;
                sel_idx   = idx;
            end
        end
    end

    always_comb begin
        grant_o = '0;
        if (sel_found) begin
            grant_o[sel_idx] = 1'b1;
        end
    end

    // Chosen entry reshaped for the operand collector
    assign disp_inst_o.opcode   = entries_i[sel_idx].inst.opcode;
    assign disp_inst_o.pc       = entries_i[sel_idx].inst.pc;
    assign disp_inst_o.act_mask = entries_i[sel_idx].inst.act_mask;
    assign disp_inst_o.tag      = entries_i[sel_idx].inst.tag;
    assign disp_inst_o.dst_reg  = entries_i[sel_idx].inst.dst_reg;
    assign disp_inst_o.operands = entries_i[sel_idx].inst.operands;

    // Winner gets lowest priority next time
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (dispatch_fire_i) begin
            ptr_q <= sel_idx + 1'b1;
        end
    end

endmodule

// File: source/wait_buffer.sv
// ################################################
// Wait buffer for decoded instructions
// Insertion, operand wake-up and removal on dispatch
// ################################################

`include "issue_settings.svh"

module wait_buffer
    import issue_inst_pkg::*;
    import issue_ctrl_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    // From decoder
    input  logic                          dec_valid_i,
    input  dec_inst_t                     dec_inst_i,
    // From execution units
    input  logic                          eu_valid_i,
    input  tag_t                          eu_tag_i,
    // From arbiter and control
    input  logic [`ISSUE_ENTRIES-1:0]     grant_i,
    input  logic                          dispatch_fire_i,
    // Buffer contents and summary
    output wb_entry_t [`ISSUE_ENTRIES-1:0] entries_o,
    output wb_status_t                    status_o
);

    localparam int IDX_W = `ISSUE_IDX_W;

    // ################################################
    // State
    // ################################################

    logic [`ISSUE_ENTRIES-1:0]      valid_q, valid_d;
    dec_inst_t [`ISSUE_ENTRIES-1:0] inst_q, inst_d;

    logic             ins_found;
    logic [IDX_W-1:0] ins_idx;

    // ################################################
    // Next state
    // ################################################

    // Lowest free slot, searched from the top down
    always_comb begin
        ins_found = 1'b0;
        ins_idx   = '0;
        for (int i = `ISSUE_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                ins_found = 1'b1;
                ins_idx   = IDX_W'(i);
            end
        end
    end

    always_comb begin
        valid_d = valid_q;
        inst_d  = inst_q;
        for (int i = 0; i < `ISSUE_ENTRIES; i++) begin
            // Granted entry leaves on a fire
            if (dispatch_fire_i && grant_i[i]) begin
                valid_d[i] = 1'b0;
            end
            // Result tag wakes up matching operands
            if (eu_valid_i && valid_q[i]) begin
                for (int op = 0; op < `ISSUE_OPERANDS; op++) begin
                    if (!inst_q[i].operands_ready[op]
                            && inst_q[i].operand_tags[op] == eu_tag_i) begin
                        inst_d[i].operands_ready[op] = 1'b1;
                    end
                end
            end
            // New instruction, slot guaranteed by the credits
            if (dec_valid_i && ins_found && ins_idx == IDX_W'(i)) begin
                valid_d[i] = 1'b1;
                inst_d[i]  = dec_inst_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Payload only matters while valid
    always_ff @(posedge clk_i) begin
        inst_q <= inst_d;
    end

    // ################################################
    // Outputs
    // ################################################

    always_comb begin
        status_o.valid = valid_q;
        for (int i = 0; i < `ISSUE_ENTRIES; i++) begin
            status_o.ready[i]  = valid_q[i] && (&inst_q[i].operands_ready);
            entries_o[i].valid = valid_q[i];
            entries_o[i].inst  = inst_q[i];
        end
    end

endmodule

// File: source/credit_counter.sv
// ################################################
// Fetch credit counter
// ################################################

`include "issue_settings.svh"

module credit_counter (
    input  logic clk_i,
    input  logic reset_i,
    // Credit consumed by a fetch grant
    input  logic take_i,
    // Credit returned by a dispatch
    input  logic give_i,
    output logic credit_left_o
);

    // One extra bit so the full count fits
    localparam int CNT_W = `ISSUE_IDX_W + 1;
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`ISSUE_ENTRIES);

    logic [CNT_W-1:0] count_q;

    // Take and give together cancel out
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= CNT_FULL;
        end else if (take_i && !give_i && count_q != '0) begin
            count_q <= count_q - 1'b1;
        end else if (give_i && !take_i && count_q != CNT_FULL) begin
            count_q <= count_q + 1'b1;
        end
    end

    // At least one free slot not yet promised to the fetcher
    assign credit_left_o = (count_q != '0);

endmodule

// File: source/issue_ctrl_pkg.sv
// ################################################
// Control types of the issue stage
// State encoding and wait buffer status vectors
// ################################################

`include "issue_settings.svh"

package issue_ctrl_pkg;

    // Issue state, one init cycle then run
    typedef enum logic {
        ISSUE_INIT,
        ISSUE_RUN
    } issue_state_e;

    // Per-entry occupancy and dispatch readiness
    typedef struct packed {
        logic [`ISSUE_ENTRIES-1:0] valid;
        // Valid and all operands ready
        logic [`ISSUE_ENTRIES-1:0] ready;
    } wb_status_t;

endpackage

// File: source/issue_inst_pkg.sv
// ################################################
// Instruction types of the issue stage
// Opcode classes, decoded, buffered and dispatched forms
// ################################################

`include "issue_settings.svh"

package issue_inst_pkg;

    typedef logic [`ISSUE_PC_W-1:0] pc_t;
    typedef logic [`ISSUE_WARP_W-1:0] act_mask_t;
    typedef logic [`ISSUE_TAG_W-1:0] tag_t;
    typedef logic [`ISSUE_REG_W-1:0] reg_idx_t;

    // Execution unit class
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MUL,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } opcode_e;

    // Instruction as delivered by the decoder
    typedef struct packed {
        opcode_e                              opcode;
        pc_t                                  pc;
        act_mask_t                            act_mask;
        tag_t                                 tag;
        reg_idx_t                             dst_reg;
        logic [`ISSUE_OPERANDS-1:0]           operands_ready;
        tag_t [`ISSUE_OPERANDS-1:0]           operand_tags;
        reg_idx_t [`ISSUE_OPERANDS-1:0]       operands;
    } dec_inst_t;

    // One slot of the wait buffer
    typedef struct packed {
        logic      valid;
        dec_inst_t inst;
    } wb_entry_t;

    // Instruction handed to the operand collector
    typedef struct packed {
        opcode_e                        opcode;
        pc_t                            pc;
        act_mask_t                      act_mask;
        tag_t                           tag;
        reg_idx_t                       dst_reg;
        reg_idx_t [`ISSUE_OPERANDS-1:0] operands;
    } disp_inst_t;

endpackage

// File: source/issue_settings.svh
// ################################################
// Sizes and widths of the issue stage
// Buffer depth, field widths and operand count
// ################################################

`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Wait buffer depth, also the number of fetch credits
`define ISSUE_ENTRIES 4
`define ISSUE_IDX_W 2

// Instruction field widths
`define ISSUE_PC_W 32
`define ISSUE_WARP_W 8
`define ISSUE_REG_W 6
`define ISSUE_TAG_W 3

// Source operands per instruction
`define ISSUE_OPERANDS 2

`endif
